/* hdl/video_settings.svh */
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// 640x480 horizontal timing, in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing, in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// text screen geometry
`define TEXT_COLS 80
`define TEXT_ROWS 30

// each glyph row is shown on LINE_REPEAT scan lines
`define CELL_WIDTH 8
`define GLYPH_ROWS 8
`define LINE_REPEAT 2

// 4 KB video memory, font in the top kilobyte
`define VRAM_ADDR_BITS 12
`define FONT_BASE 12'hC00

`endif

/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

    // cpu bus word
    typedef logic [31:0] word_t;

    // one video memory byte
    typedef logic [7:0] byte_t;

    // 0 .. 799
    typedef logic [9:0] h_count_t;

    // 0 .. 524
    typedef logic [9:0] v_count_t;

endpackage

`default_nettype wire

/* hdl/video_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_ram (
    // cpu port
    input  wire logic                       cpu_clk_i,
    input  wire logic                       cpu_chip_select_i,
    input  wire video_pkg::word_t           cpu_addr_i,
    input  wire video_pkg::word_t           cpu_write_data_i,
    input  wire logic [3:0]                 cpu_write_mask_i,
    output wire video_pkg::word_t           cpu_read_data_o,

    // pixel port, read only
    input  wire logic                       pxl_clk_i,
    input  wire logic                       pxl_chip_select_i,
    input  wire logic [`VRAM_ADDR_BITS-1:0] pxl_addr_i,
    output wire video_pkg::byte_t           pxl_data_o
);

    localparam int DEPTH = 1 << `VRAM_ADDR_BITS;
    localparam int WORD_BITS = `VRAM_ADDR_BITS - 2;

    video_pkg::byte_t mem_r [DEPTH] = '{default: '0};

    // word index, low two address bits dropped
    logic [WORD_BITS-1:0] cpu_word;

    assign cpu_word = cpu_addr_i[`VRAM_ADDR_BITS-1:2];

    video_pkg::word_t cpu_read_data_r = '0;

    // old word is returned even when bytes are written in the same cycle
    always_ff @(posedge cpu_clk_i) begin
        if (cpu_chip_select_i) begin
            for (int b = 0; b < 4; b++) begin
                cpu_read_data_r[8*b +: 8] <= mem_r[{cpu_word, 2'(b)}];
                if (cpu_write_mask_i[b]) begin
                    mem_r[{cpu_word, 2'(b)}] <= cpu_write_data_i[8*b +: 8];
                end
            end
        end
    end

    assign cpu_read_data_o = cpu_read_data_r;

    video_pkg::byte_t pxl_data_r = '0;

    // holds the last byte while not selected
    always_ff @(posedge pxl_clk_i) begin
        if (pxl_chip_select_i) begin
            pxl_data_r <= mem_r[pxl_addr_i];
        end
    end

    assign pxl_data_o = pxl_data_r;

endmodule

`default_nettype wire

/* hdl/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module vga_timing (
    input  wire logic                pxl_clk_i,
    input  wire logic                rst_i,
    output wire logic                pxl_rst_o,
    output wire video_pkg::h_count_t h_count_o,
    output wire video_pkg::v_count_t v_count_o,
    output wire logic                active_o,
    output wire logic                hsync_o,
    output wire logic                vsync_o
);

    localparam video_pkg::h_count_t H_LAST =
        video_pkg::h_count_t'(`H_TOTAL - 1);
    localparam video_pkg::h_count_t H_ACTIVE_END =
        video_pkg::h_count_t'(`H_ACTIVE);
    localparam video_pkg::h_count_t H_SYNC_START =
        video_pkg::h_count_t'(`H_ACTIVE + `H_FRONT);
    localparam video_pkg::h_count_t H_SYNC_END =
        video_pkg::h_count_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);

    localparam video_pkg::v_count_t V_LAST =
        video_pkg::v_count_t'(`V_TOTAL - 1);
    localparam video_pkg::v_count_t V_ACTIVE_END =
        video_pkg::v_count_t'(`V_ACTIVE);
    localparam video_pkg::v_count_t V_SYNC_START =
        video_pkg::v_count_t'(`V_ACTIVE + `V_FRONT);
    localparam video_pkg::v_count_t V_SYNC_END =
        video_pkg::v_count_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    // rst_i comes from the cpu domain
    logic [1:0] rst_sync_r = 2'b11;

    always_ff @(posedge pxl_clk_i) begin
        rst_sync_r <= {rst_sync_r[0], rst_i};
    end

    assign pxl_rst_o = rst_sync_r[1];

    video_pkg::h_count_t h_count_r;
    video_pkg::v_count_t v_count_r;

    always_ff @(posedge pxl_clk_i) begin
        if (rst_sync_r[1]) begin
            h_count_r <= '0;
            v_count_r <= '0;
        end else if (h_count_r == H_LAST) begin
            h_count_r <= '0;
            // end of line, step the frame
            if (v_count_r == V_LAST) begin
                v_count_r <= '0;
            end else begin
                v_count_r <= v_count_r + 1'b1;
            end
        end else begin
            h_count_r <= h_count_r + 1'b1;
        end
    end

    assign h_count_o = h_count_r;
    assign v_count_o = v_count_r;

    assign active_o = (h_count_r < H_ACTIVE_END) && (v_count_r < V_ACTIVE_END);

    // both syncs active low
    assign hsync_o = !((h_count_r >= H_SYNC_START) && (h_count_r < H_SYNC_END));
    assign vsync_o = !((v_count_r >= V_SYNC_START) && (v_count_r < V_SYNC_END));

endmodule

`default_nettype wire

/* hdl/text_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module text_renderer (
    input  wire logic                       pxl_clk_i,
    input  wire logic                       pxl_rst_i,
    input  wire video_pkg::h_count_t        h_count_i,
    input  wire video_pkg::v_count_t        v_count_i,
    input  wire logic                       active_i,
    input  wire logic                       hsync_i,
    input  wire logic                       vsync_i,
    output wire logic                       vram_select_o,
    output wire logic [`VRAM_ADDR_BITS-1:0] vram_addr_o,
    input  wire video_pkg::byte_t           vram_data_i,
    output wire logic                       pixel_o,
    output wire logic                       de_o,
    output wire logic                       hsync_o,
    output wire logic                       vsync_o
);

    localparam int ADDR_W = `VRAM_ADDR_BITS;
    localparam int H_BITS = $bits(video_pkg::h_count_t);
    localparam int V_BITS = $bits(video_pkg::v_count_t);

    localparam int CELL_SHIFT = $clog2(`CELL_WIDTH);
    localparam int LINE_SHIFT = $clog2(`LINE_REPEAT);
    localparam int ROW_SHIFT = $clog2(`GLYPH_ROWS * `LINE_REPEAT);

    // cell phases: code request, glyph request, glyph on the bus
    localparam logic [CELL_SHIFT-1:0] CHAR_REQ = '0;
    localparam logic [CELL_SHIFT-1:0] GLYPH_REQ = CELL_SHIFT'(1);
    localparam logic [CELL_SHIFT-1:0] GLYPH_READY = CELL_SHIFT'(2);
    localparam logic [CELL_SHIFT-1:0] LAST_PHASE = CELL_SHIFT'(`CELL_WIDTH - 1);

    localparam logic [ADDR_W-1:0] FONT_BASE_ADDR = ADDR_W'(`FONT_BASE);

    // one cell of fetch ahead of the shifter
    localparam int PIPE_LEN = `CELL_WIDTH;

    logic [CELL_SHIFT-1:0]           phase;
    logic [H_BITS-CELL_SHIFT-1:0]    cell_col;
    logic [V_BITS-ROW_SHIFT-1:0]     cell_row;
    logic [ROW_SHIFT-LINE_SHIFT-1:0] glyph_row;

    assign phase = h_count_i[CELL_SHIFT-1:0];
    assign cell_col = h_count_i[H_BITS-1:CELL_SHIFT];
    assign cell_row = v_count_i[V_BITS-1:ROW_SHIFT];
    assign glyph_row = v_count_i[ROW_SHIFT-1:LINE_SHIFT];

    logic in_text;

    assign in_text = active_i && (cell_col < `TEXT_COLS) && (cell_row < `TEXT_ROWS);

    logic [ADDR_W-1:0] char_addr;
    logic [ADDR_W-1:0] glyph_addr;

    assign char_addr = ADDR_W'(cell_row) * ADDR_W'(`TEXT_COLS) + ADDR_W'(cell_col);

    // code byte is on the bus during the glyph request
    assign glyph_addr = FONT_BASE_ADDR + ADDR_W'({vram_data_i[6:0], glyph_row});

    assign vram_select_o = in_text && ((phase == CHAR_REQ) || (phase == GLYPH_REQ));
    assign vram_addr_o = (phase == CHAR_REQ) ? char_addr : glyph_addr;

    video_pkg::byte_t glyph_r;
    video_pkg::byte_t shift_r;
    logic             inv_r;

    always_ff @(posedge pxl_clk_i) begin
        if (phase == GLYPH_REQ) begin
            inv_r <= vram_data_i[7];
        end
        if (phase == GLYPH_READY) begin
            glyph_r <= vram_data_i;
        end
        // reload at the cell boundary, msb is the leftmost pixel
        if (phase == LAST_PHASE) begin
            shift_r <= glyph_r ^ {$bits(video_pkg::byte_t){inv_r}};
        end else begin
            shift_r <= {shift_r[$bits(video_pkg::byte_t)-2:0], 1'b0};
        end
    end

    logic [PIPE_LEN-1:0] active_pipe_r;
    logic [PIPE_LEN-1:0] hsync_pipe_r;
    logic [PIPE_LEN-1:0] vsync_pipe_r;

    logic pixel_r;
    logic de_r;
    logic hsync_r;
    logic vsync_r;

    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            active_pipe_r <= '0;
            hsync_pipe_r <= '1;
            vsync_pipe_r <= '1;
            pixel_r <= 1'b0;
            de_r <= 1'b0;
            hsync_r <= 1'b1;
            vsync_r <= 1'b1;
        end else begin
            active_pipe_r <= {active_pipe_r[PIPE_LEN-2:0], active_i};
            hsync_pipe_r <= {hsync_pipe_r[PIPE_LEN-2:0], hsync_i};
            vsync_pipe_r <= {vsync_pipe_r[PIPE_LEN-2:0], vsync_i};
            pixel_r <= active_pipe_r[PIPE_LEN-1] & shift_r[$bits(video_pkg::byte_t)-1];
            de_r <= active_pipe_r[PIPE_LEN-1];
            hsync_r <= hsync_pipe_r[PIPE_LEN-1];
            vsync_r <= vsync_pipe_r[PIPE_LEN-1];
        end
    end

    assign pixel_o = pixel_r;
    assign de_o = de_r;
    assign hsync_o = hsync_r;
    assign vsync_o = vsync_r;

endmodule

`default_nettype wire

/* hdl/text_display.sv */
`timescale 1ns/1ps
`default_nettype none

module text_display (
    input  wire logic             cpu_clk_i,
    input  wire logic             rst_i,
    input  wire logic             pxl_clk_i,

    // cpu bus
    input  wire logic             cpu_chip_select_i,
    input  wire video_pkg::word_t cpu_addr_i,
    input  wire video_pkg::word_t cpu_write_data_i,
    input  wire logic [3:0]       cpu_write_mask_i,
    output wire video_pkg::word_t cpu_read_data_o,

    // display
    output wire logic             hsync_o,
    output wire logic             vsync_o,
    output wire logic             de_o,
    output wire logic             pixel_o
);

    logic                pxl_rst;
    video_pkg::h_count_t h_count;
    video_pkg::v_count_t v_count;
    logic                active;
    logic                hsync_raw;
    logic                vsync_raw;

    logic                vram_select;
    logic [11:0]         vram_addr;
    video_pkg::byte_t    vram_data;

    video_ram u_video_ram (
        .cpu_clk_i         (cpu_clk_i),
        .cpu_chip_select_i (cpu_chip_select_i),
        .cpu_addr_i        (cpu_addr_i),
        .cpu_write_data_i  (cpu_write_data_i),
        .cpu_write_mask_i  (cpu_write_mask_i),
        .cpu_read_data_o   (cpu_read_data_o),
        .pxl_clk_i         (pxl_clk_i),
        .pxl_chip_select_i (vram_select),
        .pxl_addr_i        (vram_addr),
        .pxl_data_o        (vram_data)
    );

    vga_timing u_vga_timing (
        .pxl_clk_i (pxl_clk_i),
        .rst_i     (rst_i),
        .pxl_rst_o (pxl_rst),
        .h_count_o (h_count),
        .v_count_o (v_count),
        .active_o  (active),
        .hsync_o   (hsync_raw),
        .vsync_o   (vsync_raw)
    );

    text_renderer u_text_renderer (
        .pxl_clk_i     (pxl_clk_i),
        .pxl_rst_i     (pxl_rst),
        .h_count_i     (h_count),
        .v_count_i     (v_count),
        .active_i      (active),
        .hsync_i       (hsync_raw),
        .vsync_i       (vsync_raw),
        .vram_select_o (vram_select),
        .vram_addr_o   (vram_addr),
        .vram_data_i   (vram_data),
        .pixel_o       (pixel_o),
        .de_o          (de_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o)
    );

endmodule

`default_nettype wire

/* test/text_display_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module text_display_checker (
    input wire logic             cpu_clk_i,
    input wire logic             pxl_clk_i,
    input wire logic             rst_i,
    input wire logic             pxl_rst_i,
    input wire logic             cpu_chip_select_i,
    input wire video_pkg::word_t cpu_read_data_i,
    input wire logic             hsync_i,
    input wire logic             de_i,
    input wire logic             pixel_i
);

    // length of the hsync low pulse so far
    logic [9:0] low_count_r;

    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            low_count_r <= '0;
        end else if (!hsync_i) begin
            low_count_r <= low_count_r + 1'b1;
        end else begin
            low_count_r <= '0;
        end
    end

    blank_pixel: assert property (@(posedge pxl_clk_i) disable iff (pxl_rst_i)
        !de_i |-> !pixel_i)
        else $error("pixel_o is high outside the active area");

    read_hold: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        !cpu_chip_select_i |=> $stable(cpu_read_data_i))
        else $error("cpu_read_data_o changed without a select");

    // checked on the rising edge that ends each pulse
    hsync_width: assert property (@(posedge pxl_clk_i) disable iff (pxl_rst_i)
        $rose(hsync_i) |-> (low_count_r == `H_SYNC))
        else $error("hsync_o low pulse has the wrong length");

endmodule

bind text_display text_display_checker u_checker (
    .cpu_clk_i         (cpu_clk_i),
    .pxl_clk_i         (pxl_clk_i),
    .rst_i             (rst_i),
    .pxl_rst_i         (pxl_rst),
    .cpu_chip_select_i (cpu_chip_select_i),
    .cpu_read_data_i   (cpu_read_data_o),
    .hsync_i           (hsync_o),
    .de_i              (de_o),
    .pixel_i           (pixel_o)
);

`default_nettype wire

/* test/text_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module text_display_tb;

    localparam int FRAME_CLOCKS = `H_TOTAL * `V_TOTAL;
    localparam int WAIT_LIMIT = 2 * FRAME_CLOCKS;
    localparam int TEXT_BYTES = `TEXT_COLS * `TEXT_ROWS;
    localparam int CELL_HEIGHT = `GLYPH_ROWS * `LINE_REPEAT;
    localparam int WORD_COUNT = (1 << `VRAM_ADDR_BITS) / 4;
    localparam int PRINT_LIMIT = 20;

    logic             cpu_clk;
    logic             pxl_clk;
    logic             rst;
    logic             cpu_chip_select;
    video_pkg::word_t cpu_addr;
    video_pkg::word_t cpu_write_data;
    logic [3:0]       cpu_write_mask;
    video_pkg::word_t cpu_read_data;
    logic             hsync;
    logic             vsync;
    logic             de;
    logic             pixel;

    video_pkg::byte_t mem_model [1 << `VRAM_ADDR_BITS] = '{default: '0};
    logic [31:0]      lfsr_state = 32'ha622_bdd3;

    int read_errors = 0;
    int video_errors = 0;
    int timing_errors = 0;
    int timeouts = 0;

    text_display dut (
        .cpu_clk_i         (cpu_clk),
        .rst_i             (rst),
        .pxl_clk_i         (pxl_clk),
        .cpu_chip_select_i (cpu_chip_select),
        .cpu_addr_i        (cpu_addr),
        .cpu_write_data_i  (cpu_write_data),
        .cpu_write_mask_i  (cpu_write_mask),
        .cpu_read_data_o   (cpu_read_data),
        .hsync_o           (hsync),
        .vsync_o           (vsync),
        .de_o              (de),
        .pixel_o           (pixel)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #2 cpu_clk = ~cpu_clk;
    end

    initial begin
        pxl_clk = 1'b0;
        forever #3 pxl_clk = ~pxl_clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string name, input video_pkg::word_t got,
                              input video_pkg::word_t expected);
        if (got !== expected) begin
            read_errors++;
            if (read_errors <= PRINT_LIMIT) begin
                $display("ERROR %s got 0x%08h expected 0x%08h", name, got, expected);
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected,
                             input int x, input int y);
        if (got !== expected) begin
            video_errors++;
            if (video_errors <= PRINT_LIMIT) begin
                $display("ERROR %s got 0x%0h expected 0x%0h at x %0d y %0d",
                         name, got, expected, x, y);
            end
        end
    endtask

    function automatic video_pkg::word_t model_word(input logic [9:0] word_index);
        video_pkg::word_t word;
        word = '0;
        for (int b = 0; b < 4; b++) begin
            word = {mem_model[{word_index, 2'(b)}], word[31:8]};
        end
        return word;
    endfunction

    // one select cycle, read data sampled a cycle later
    task automatic cpu_access(input video_pkg::word_t addr, input video_pkg::word_t data,
                              input logic [3:0] mask, output video_pkg::word_t read_data);
        @(posedge cpu_clk);
        cpu_chip_select <= 1'b1;
        cpu_addr <= addr;
        cpu_write_data <= data;
        cpu_write_mask <= mask;
        @(posedge cpu_clk);
        cpu_chip_select <= 1'b0;
        cpu_write_mask <= '0;
        @(negedge cpu_clk);
        read_data = cpu_read_data;
    endtask

    task automatic access_and_check(input video_pkg::word_t addr, input video_pkg::word_t data,
                                    input logic [3:0] mask);
        logic [9:0]       word_index;
        video_pkg::word_t expected;
        video_pkg::word_t got;
        logic [3:0]       lane_mask;
        video_pkg::word_t lane_data;
        word_index = addr[`VRAM_ADDR_BITS-1:2];
        expected = model_word(word_index);
        cpu_access(addr, data, mask, got);
        check_word("cpu_read_data_o", got, expected);
        lane_mask = mask;
        lane_data = data;
        for (int b = 0; b < 4; b++) begin
            if (lane_mask[0]) begin
                mem_model[{word_index, 2'(b)}] = lane_data[7:0];
            end
            lane_mask = lane_mask >> 1;
            lane_data = lane_data >> 8;
        end
    endtask

    task automatic run_memory_test();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] r;
        for (int i = 0; i < 256; i++) begin
            random_bits(32, addr);
            random_bits(32, data);
            random_bits(4, r);
            // every fourth write is full width and read back at once
            if (i % 4 == 0) begin
                access_and_check(addr, data, 4'hf);
                access_and_check(addr, '0, 4'h0);
            end else begin
                access_and_check(addr, data, r[3:0]);
            end
        end
        for (int i = 0; i < 256; i++) begin
            random_bits(32, addr);
            access_and_check(addr, '0, 4'h0);
        end
    endtask

    // random font and text, inverse codes in a checkerboard
    task automatic load_screen();
        logic [31:0] data;
        logic [31:0] r;
        int          a;
        for (int w = 0; w < WORD_COUNT; w++) begin
            data = '0;
            for (int b = 0; b < 4; b++) begin
                random_bits(8, r);
                a = 4 * w + b;
                if (a < TEXT_BYTES) begin
                    r[7] = ((a % `TEXT_COLS) + (a / `TEXT_COLS)) % 2 == 1;
                end
                data = {r[7:0], data[31:8]};
            end
            access_and_check(32'(4 * w), data, 4'hf);
        end
    endtask

    function automatic logic expected_pixel(input int x, input int y);
        video_pkg::byte_t code;
        video_pkg::byte_t glyph;
        code = mem_model[12'((y / CELL_HEIGHT) * `TEXT_COLS + x / `CELL_WIDTH)];
        glyph = mem_model[12'(`FONT_BASE + int'(code[6:0]) * `GLYPH_ROWS
                              + (y % CELL_HEIGHT) / `LINE_REPEAT)];
        return glyph[3'(`CELL_WIDTH - 1 - x % `CELL_WIDTH)] ^ code[7];
    endfunction

    task automatic check_frame();
        logic prev_hsync;
        logic prev_vsync;
        logic prev_de;
        logic found;
        logic started;
        logic done;
        logic exp_de;
        int   clocks;
        int   last_hfall;
        int   h_pos;
        int   v_pos;
        int   line_de;
        int   lines;
        found = 1'b0;
        @(negedge pxl_clk);
        prev_vsync = vsync;
        for (int i = 0; i < WAIT_LIMIT && !found; i++) begin
            @(negedge pxl_clk);
            found = (prev_vsync === 1'b1) && (vsync === 1'b0);
            prev_vsync = vsync;
        end
        if (!found) begin
            timeouts++;
            $display("timeout while waiting for a vsync_o falling edge");
            return;
        end
        prev_hsync = hsync;
        prev_de = de;
        started = 1'b0;
        done = 1'b0;
        clocks = 0;
        last_hfall = -1;
        h_pos = 0;
        v_pos = 0;
        line_de = 0;
        lines = 0;
        for (int i = 0; i < FRAME_CLOCKS + `H_TOTAL && !done; i++) begin
            @(negedge pxl_clk);
            clocks++;
            if (!started && de === 1'b1) begin
                started = 1'b1;
            end
            // position counted from the first enabled pixel
            if (started) begin
                exp_de = (h_pos < `H_ACTIVE) && (v_pos < `V_ACTIVE);
                check_bit("de_o", de, exp_de, h_pos, v_pos);
                check_bit("pixel_o", pixel, exp_de ? expected_pixel(h_pos, v_pos) : 1'b0,
                          h_pos, v_pos);
                check_bit("hsync_o", hsync, !(h_pos >= `H_ACTIVE + `H_FRONT
                          && h_pos < `H_ACTIVE + `H_FRONT + `H_SYNC), h_pos, v_pos);
                check_bit("vsync_o", vsync, !(v_pos >= `V_ACTIVE + `V_FRONT
                          && v_pos < `V_ACTIVE + `V_FRONT + `V_SYNC), h_pos, v_pos);
                h_pos++;
                if (h_pos == `H_TOTAL) begin
                    h_pos = 0;
                    v_pos++;
                end
            end
            if (de === 1'b1) begin
                line_de++;
            end
            if (prev_de === 1'b1 && de === 1'b0) begin
                if (line_de != `H_ACTIVE) begin
                    timing_errors++;
                    $display("line %0d has %0d enabled pixels instead of %0d",
                             lines, line_de, `H_ACTIVE);
                end
                lines++;
                line_de = 0;
            end
            if (prev_hsync === 1'b1 && hsync === 1'b0) begin
                if (last_hfall >= 0 && clocks - last_hfall != `H_TOTAL) begin
                    timing_errors++;
                    $display("hsync_o fell %0d clocks after the previous fall",
                             clocks - last_hfall);
                end
                last_hfall = clocks;
            end
            if (prev_vsync === 1'b1 && vsync === 1'b0) begin
                if (clocks != FRAME_CLOCKS) begin
                    timing_errors++;
                    $display("vsync_o fell %0d clocks after the previous fall", clocks);
                end
                done = 1'b1;
            end
            prev_hsync = hsync;
            prev_vsync = vsync;
            prev_de = de;
        end
        if (!done) begin
            timeouts++;
            $display("timeout while waiting for the next vsync_o falling edge");
        end else if (lines != `V_ACTIVE) begin
            timing_errors++;
            $display("frame had %0d enabled lines instead of %0d", lines, `V_ACTIVE);
        end
    endtask

    initial begin
        rst = 1'b1;
        cpu_chip_select = 1'b0;
        cpu_addr = '0;
        cpu_write_data = '0;
        cpu_write_mask = '0;
        repeat (4) @(posedge cpu_clk);
        rst <= 1'b0;
        run_memory_test();
        load_screen();
        check_frame();
        $display("errors: read data %0d, video %0d, geometry %0d, timeouts %0d",
                 read_errors, video_errors, timing_errors, timeouts);
        if (read_errors + video_errors + timing_errors + timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/video_pkg.sv
hdl/video_ram.sv
hdl/vga_timing.sv
hdl/text_renderer.sv
hdl/text_display.sv
test/text_display_checker.sv
test/text_display_tb.sv

/* run.sh */
#!/bin/sh
# builds and runs the text display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f \
    --top-module text_display_tb \
    -o text_display_sim

# a failing assertion stops the simulation early, the search below still decides
output=$(./obj_dir/text_display_sim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
